/* m4_config.svh */
`ifndef M4_CONFIG_SVH
`define M4_CONFIG_SVH

// instruction word width
`define M4_INS_W 16

// microcode entry address width
`define M4_UA_W 7

// prefetch queue entries
`define M4_QDEPTH 2

// entry of the halt microprogram
`define M4_UA_HALT 7'h00

// entry taken by any opcode the decoder does not list
`define M4_UA_UNDEF 7'h01

`endif

/* m4Pkg.sv */
package m4Pkg;

   // control states of the microprogram sequencer
   typedef enum logic [2:0] {
      SEQ_IDLE   = 3'd0,  // waiting on the prefetch queue
      SEQ_DECODE = 3'd1,  // entry latched, length lookup
      SEQ_EXEC   = 3'd2,  // stepping microcycles
      SEQ_TRAP   = 3'd3,  // one-cycle undefined opcode service
      SEQ_HALT   = 3'd4   // parked until cont
   } seqState_t;

   // how a microprogram leaves its last microcycle
   typedef enum logic [1:0] {
      EXIT_NEXT = 2'd0,   // normal completion, fetch next
      EXIT_HALT = 2'd1,   // stop until continued
      EXIT_TRAP = 2'd2    // undefined opcode service
   } exitKind_t;

endpackage

/* plmDec.sv */
`timescale 1ns/10ps
`include "m4_config.svh"

module plmDec (
   input  logic [`M4_INS_W-1:0] ins,  // instruction word
   output logic                 bf,   // byte operation
   output logic [`M4_UA_W-1:0]  ad    // microcode entry
);

   logic srcRegMode;  // source mode 0
   logic dstRegMode;  // destination mode 0
   logic bothReg;     // Rs,Rd form of double operand

   assign srcRegMode = (ins[11:9] == 3'b000);
   assign dstRegMode = (ins[5:3] == 3'b000);
   assign bothReg    = srcRegMode & dstRegMode;

   always_comb begin
      casez (ins)
         16'o105???,                                      // clrb..tstb
         16'o1060??, 16'o1061??, 16'o1062??, 16'o1063??,  // byte shifts
         16'o1064??, 16'o1067??,                          // mtps mfps
         16'o11????, 16'o12????, 16'o13????,              // movb cmpb bitb
         16'o14????, 16'o15????: bf = 1'b1;               // bicb bisb
         default:                bf = 1'b0;
      endcase
   end

   always_comb begin
      casez (ins)
         16'o000000: ad = `M4_UA_HALT;                   // halt
         16'o000001: ad = 7'h03;                         // wait
         16'o000002,
         16'o000006: ad = 7'h02;                         // rti/rtt
         16'o000003: ad = 7'h04;                         // bpt
         16'o000004: ad = 7'h07;                         // iot
         16'o000005: ad = 7'h06;                         // reset
         16'o0001??: ad = 7'h0E;                         // jmp
         16'o00020?: ad = 7'h36;                         // rts
         16'o00024?,
         16'o00025?: ad = 7'h40;                         // clear cc bits
         16'o00026?,
         16'o00027?: ad = 7'h43;                         // set cc bits
         16'o0003??: ad = dstRegMode ? 7'h44 : 7'h41;    // swab
         16'o0004??, 16'o0005??, 16'o0006??, 16'o0007??,
         16'o001???, 16'o002???, 16'o003???,
         16'o100???, 16'o101???, 16'o102???,
         16'o103???: ad = 7'h1F;                         // all branches
         16'o004???: ad = 7'h37;                         // jsr

         // single operand word group, Rd form has its own entry
         16'o0050??: ad = dstRegMode ? 7'h22 : 7'h12;    // clr
         16'o0051??: ad = dstRegMode ? 7'h24 : 7'h14;    // com
         16'o0052??: ad = dstRegMode ? 7'h26 : 7'h16;    // inc
         16'o0053??: ad = dstRegMode ? 7'h28 : 7'h18;    // dec
         16'o0054??: ad = dstRegMode ? 7'h2A : 7'h1A;    // neg
         16'o0055??: ad = dstRegMode ? 7'h4D : 7'h0D;    // adc
         16'o0056??: ad = dstRegMode ? 7'h4A : 7'h53;    // sbc
         16'o0057??: ad = dstRegMode ? 7'h6C : 7'h2C;    // tst
         16'o0060??: ad = dstRegMode ? 7'h55 : 7'h15;    // ror
         16'o0061??: ad = dstRegMode ? 7'h56 : 7'h17;    // rol
         16'o0062??: ad = dstRegMode ? 7'h5B : 7'h1B;    // asr
         16'o0063??: ad = dstRegMode ? 7'h5C : 7'h1D;    // asl
         16'o0064??: ad = 7'h09;                         // mark
         16'o0067??: ad = 7'h08;                         // sxt

         // double operand group
         16'o01????: ad = bothReg ? 7'h30 : 7'h31;       // mov
         16'o02????: ad = bothReg ? 7'h3A : 7'h13;       // cmp
         16'o03????: ad = bothReg ? 7'h3C : 7'h1C;       // bit
         16'o04????: ad = bothReg ? 7'h3E : 7'h1E;       // bic
         16'o05????: ad = bothReg ? 7'h20 : 7'h10;       // bis
         16'o06????: begin                               // add
            if (!srcRegMode)
               ad = 7'h35;                               // memory source
            else if (!dstRegMode)
               ad = 7'h34;                               // Rs to memory
            else
               ad = 7'h74;                               // Rs to Rd
         end
         16'o11????: ad = bothReg ? 7'h32 : 7'h33;       // movb
         16'o12????: ad = 7'h3D;                         // cmpb
         16'o13????: ad = 7'h3F;                         // bitb
         16'o14????: ad = 7'h21;                         // bicb
         16'o15????: ad = 7'h23;                         // bisb
         16'o16????: ad = bothReg ? 7'h3B : 7'h19;       // sub

         // eis, fis and sob
         16'o070???: ad = 7'h47;                         // mul
         16'o071???: ad = 7'h48;                         // div
         16'o072???: ad = 7'h42;                         // ash
         16'o073???: ad = 7'h45;                         // ashc
         16'o074???: ad = 7'h0B;                         // xor
         16'o07500?, 16'o07501?,
         16'o07502?, 16'o07503?: ad = 7'h0F;             // fadd..fdiv
         16'o077???: ad = 7'h0A;                         // sob

         // software traps
         16'o1040??, 16'o1041??,
         16'o1042??, 16'o1043??: ad = 7'h39;             // emt
         16'o1044??, 16'o1045??,
         16'o1046??, 16'o1047??: ad = 7'h38;             // trap

         // single operand byte group, no Rd alternates here
         16'o1050??: ad = 7'h25;                         // clrb
         16'o1051??: ad = 7'h27;                         // comb
         16'o1052??: ad = 7'h29;                         // incb
         16'o1053??: ad = 7'h2B;                         // decb
         16'o1054??: ad = 7'h2D;                         // negb
         16'o1055??: ad = 7'h51;                         // adcb
         16'o1056??: ad = 7'h52;                         // sbcb
         16'o1057??: ad = 7'h2F;                         // tstb
         16'o1060??: ad = 7'h54;                         // rorb
         16'o1061??: ad = 7'h59;                         // rolb
         16'o1062??: ad = 7'h5A;                         // asrb
         16'o1063??: ad = 7'h5F;                         // aslb
         16'o1064??: ad = 7'h2E;                         // mtps
         16'o1067??: ad = 7'h0C;                         // mfps
         default:    ad = `M4_UA_UNDEF;                  // reserved opcode
      endcase
   end

endmodule

/* insQueue.sv */
`timescale 1ns/10ps
`include "m4_config.svh"

module insQueue (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 insStrobe,  // bus side word strobe
   input  logic [`M4_INS_W-1:0] insWord,
   input  logic                 pop,        // from sequencer
   output logic [`M4_INS_W-1:0] qWord,      // head of queue
   output logic                 qEmpty,
   output logic                 insFull
);

   localparam int ptrW = (`M4_QDEPTH > 1) ? $clog2(`M4_QDEPTH) : 1;
   localparam int cntW = $clog2(`M4_QDEPTH + 1);

   logic [`M4_INS_W-1:0] mem [`M4_QDEPTH];  // word storage
   logic [ptrW-1:0]      rdPtr;
   logic [ptrW-1:0]      wrPtr;
   logic [cntW-1:0]      count;             // words held
   logic                 doPush;
   logic                 doPop;

   assign doPush  = insStrobe & ~insFull;   // strobe while full is lost
   assign doPop   = pop & ~qEmpty;
   assign qEmpty  = (count == '0);
   assign insFull = (count == cntW'(`M4_QDEPTH));
   assign qWord   = mem[rdPtr];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rdPtr <= '0;
         wrPtr <= '0;
         count <= '0;
      end else begin
         if (doPush)
            wrPtr <= (wrPtr == ptrW'(`M4_QDEPTH - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop)
            rdPtr <= (rdPtr == ptrW'(`M4_QDEPTH - 1)) ? '0 : rdPtr + 1'b1;
         case ({doPush, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (doPush)
         mem[wrPtr] <= insWord;
   end

   // sequencer must only pop a non-empty queue
   popNotEmpty: assert property (@(posedge clk) disable iff (!rstN)
      pop |-> !qEmpty)
      else $error("insQueue pop while empty");

   // bus side has to hold off once insFull is up
   pushNotFull: assert property (@(posedge clk) disable iff (!rstN)
      insStrobe |-> !insFull)
      else $error("insQueue strobe dropped while full");

endmodule

/* mcRom.sv */
`timescale 1ns/10ps
`include "m4_config.svh"

module mcRom (
   input  logic [`M4_UA_W-1:0] uAddr,     // microcode entry
   output logic [1:0]          stepLen,   // microcycles minus one
   output m4Pkg::exitKind_t    exitKind
);

   import m4Pkg::*;

   localparam logic [1:0] len1 = 2'd0;
   localparam logic [1:0] len2 = 2'd1;
   localparam logic [1:0] len3 = 2'd2;
   localparam logic [1:0] len4 = 2'd3;

   always_comb begin
      case (uAddr)
         `M4_UA_HALT: begin
            stepLen  = len1;
            exitKind = EXIT_HALT;    // park after halt
         end
         `M4_UA_UNDEF: begin
            stepLen  = len1;
            exitKind = EXIT_TRAP;    // reserved opcode service
         end
         7'h30, 7'h32,               // mov/movb Rs,Rd
         7'h3A, 7'h3B, 7'h3C,        // cmp sub bit Rs,Rd
         7'h3E, 7'h20,               // bic bis Rs,Rd
         7'h74: begin                // add Rs,Rd
            stepLen  = len1;
            exitKind = EXIT_NEXT;
         end
         7'h31, 7'h33,               // mov/movb memory
         7'h13, 7'h1C, 7'h1E,        // cmp bit bic memory
         7'h10, 7'h35,               // bis add memory
         7'h19: begin                // sub memory
            stepLen  = len4;
            exitKind = EXIT_NEXT;
         end
         7'h1F: begin                // branch
            stepLen  = len2;
            exitKind = EXIT_NEXT;
         end
         default: begin              // everything else
            stepLen  = len3;
            exitKind = EXIT_NEXT;
         end
      endcase
   end

endmodule

/* mcSequencer.sv */
`timescale 1ns/10ps
`include "m4_config.svh"

module mcSequencer (
   input  logic                clk,
   input  logic                rstN,
   input  logic                qEmpty,
   output logic                pop,       // take head of queue
   input  logic [`M4_UA_W-1:0] ad,        // decoded entry
   input  logic                bf,        // decoded byte flag
   input  logic [1:0]          stepLen,   // from rom
   input  m4Pkg::exitKind_t    exitKind,  // from rom
   input  logic                cont,      // release halt
   output logic [`M4_UA_W-1:0] uAddr,
   output logic                byteOp,
   output logic                busy,
   output logic                insDone,
   output logic [`M4_UA_W-1:0] doneAddr,
   output logic                trap,
   output logic                halted
);

   import m4Pkg::*;

   seqState_t  state;
   seqState_t  stateNext;
   logic [1:0] stepCnt;   // microcycles left after this one
   logic       byteReg;   // latched byte flag
   logic       lastStep;  // final microcycle of exec
   logic       finish;    // exec ends without trap

   assign pop      = (state == SEQ_IDLE) & ~qEmpty;
   assign busy     = (state == SEQ_DECODE) | (state == SEQ_EXEC);
   assign byteOp   = busy & byteReg;
   assign trap     = (state == SEQ_TRAP);   // one cycle there
   assign halted   = (state == SEQ_HALT);
   assign lastStep = (state == SEQ_EXEC) & (stepCnt == 2'd0);
   assign finish   = lastStep & (exitKind != EXIT_TRAP);

   always_comb begin
      stateNext = state;
      case (state)
         SEQ_IDLE:   if (!qEmpty) stateNext = SEQ_DECODE;
         SEQ_DECODE: stateNext = SEQ_EXEC;
         SEQ_EXEC: begin
            if (lastStep) begin
               case (exitKind)
                  EXIT_HALT: stateNext = SEQ_HALT;
                  EXIT_TRAP: stateNext = SEQ_TRAP;
                  default:   stateNext = SEQ_IDLE;
               endcase
            end
         end
         SEQ_TRAP:   stateNext = SEQ_IDLE;
         SEQ_HALT:   if (cont) stateNext = SEQ_IDLE;
         default:    stateNext = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state   <= SEQ_IDLE;
         stepCnt <= 2'd0;
         insDone <= 1'b0;
      end else begin
         state   <= stateNext;
         insDone <= finish;                 // lands with the idle cycle
         if (state == SEQ_DECODE)
            stepCnt <= stepLen;             // rom sees the latched entry
         else if ((state == SEQ_EXEC) && !lastStep)
            stepCnt <= stepCnt - 1'b1;
      end
   end

   // entry and byte flag are captured on the pop edge
   always_ff @(posedge clk) begin
      if (pop) begin
         uAddr   <= ad;
         byteReg <= bf;
      end
      if (finish)
         doneAddr <= uAddr;
   end

   // each microprogram ends in exactly one of done or trap
   doneXorTrap: assert property (@(posedge clk) disable iff (!rstN)
      lastStep |=> (insDone ^ trap))
      else $error("mcSequencer exit without single done or trap");

   // while halted nothing runs and the queue is left alone
   haltParks: assert property (@(posedge clk) disable iff (!rstN)
      (halted && !cont) |=> (halted && !busy && !pop))
      else $error("mcSequencer left halt without cont");

endmodule

/* m4Decode.sv */
`timescale 1ns/10ps
`include "m4_config.svh"

module m4Decode (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 insStrobe,
   input  logic [`M4_INS_W-1:0] insWord,
   input  logic                 cont,
   output logic                 insFull,
   output logic [`M4_UA_W-1:0]  uAddr,
   output logic                 byteOp,
   output logic                 busy,
   output logic                 insDone,
   output logic [`M4_UA_W-1:0]  doneAddr,
   output logic                 trap,
   output logic                 halted
);

   import m4Pkg::*;

   logic [`M4_INS_W-1:0] qWord;     // head word into the plm
   logic                 qEmpty;
   logic                 pop;
   logic                 bf;
   logic [`M4_UA_W-1:0]  ad;
   logic [1:0]           stepLen;   // microcycles minus one
   exitKind_t            exitKind;

   insQueue uQueue (
      .clk       (clk),
      .rstN      (rstN),
      .insStrobe (insStrobe),
      .insWord   (insWord),
      .pop       (pop),
      .qWord     (qWord),
      .qEmpty    (qEmpty),
      .insFull   (insFull)
   );

   plmDec uPlm (
      .ins (qWord),  // decoded straight off the queue head
      .bf  (bf),
      .ad  (ad)
   );

   mcRom uRom (
      .uAddr    (uAddr),
      .stepLen  (stepLen),
      .exitKind (exitKind)
   );

   mcSequencer uSeq (
      .clk      (clk),
      .rstN     (rstN),
      .qEmpty   (qEmpty),
      .pop      (pop),
      .ad       (ad),
      .bf       (bf),
      .stepLen  (stepLen),
      .exitKind (exitKind),
      .cont     (cont),
      .uAddr    (uAddr),
      .byteOp   (byteOp),
      .busy     (busy),
      .insDone  (insDone),
      .doneAddr (doneAddr),
      .trap     (trap),
      .halted   (halted)
   );

endmodule

/* m4DecodeTb.sv */
`timescale 1ns/10ps
`include "m4_config.svh"

module m4DecodeTb;

   localparam int numDirected = 13;                    // mov..jsr set
   localparam int numTable    = 16;                    // plus undefs and halt
   localparam int wordCount   = 2 * numDirected + 12;  // every strobed word
   localparam int tickLimit   = wordCount * 8 + 200;

   logic                 clk;
   logic                 rstN;
   logic                 insStrobe;
   logic [`M4_INS_W-1:0] insWord;
   logic                 cont;
   logic                 insFull;
   logic [`M4_UA_W-1:0]  uAddr;
   logic                 byteOp;
   logic                 busy;
   logic                 insDone;
   logic [`M4_UA_W-1:0]  doneAddr;
   logic                 trap;
   logic                 halted;

   logic [`M4_INS_W-1:0] tblWord [numTable];  // opcode to entry and byte flag
   logic [`M4_UA_W-1:0]  tblAddr [numTable];
   logic                 tblBf   [numTable];

   logic [`M4_UA_W-1:0] sbAddr  [$];  // scoreboard oldest first
   logic                sbBf    [$];
   int                  sbDue   [$];  // cycle insDone is expected
   logic                sbTimed [$];  // entered an empty idle front end

   logic [`M4_UA_W-1:0] headAddr;
   logic                headBf;
   logic                headValid;
   int                  headDue;
   logic                headTimed;

   int    cyc;
   int    errCount;
   int    doneCount;
   int    trapCount;
   string testName;

   m4Decode dut (
      .clk       (clk),
      .rstN      (rstN),
      .insStrobe (insStrobe),
      .insWord   (insWord),
      .cont      (cont),
      .insFull   (insFull),
      .uAddr     (uAddr),
      .byteOp    (byteOp),
      .busy      (busy),
      .insDone   (insDone),
      .doneAddr  (doneAddr),
      .trap      (trap),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   task automatic reportValue(input string check, input int expVal, input int actVal);
      errCount++;
      $display("Error %s %s expected 'h%0h actual 'h%0h", testName, check, expVal, actVal);
   endtask

   task automatic reportFailure(input string what);
      errCount++;
      $display("%s: %s", testName, what);
   endtask

   task automatic setEntry(input int i, input logic [`M4_INS_W-1:0] w,
                           input logic [`M4_UA_W-1:0] a, input logic b);
      tblWord[i] = w;
      tblAddr[i] = a;
      tblBf[i]   = b;
   endtask

   // microcycles of each microprogram
   function automatic int cyclesFor(input logic [`M4_UA_W-1:0] a);
      case (a)
         `M4_UA_HALT, `M4_UA_UNDEF:                                return 1;
         7'h30, 7'h32, 7'h3A, 7'h3B, 7'h3C, 7'h3E, 7'h20, 7'h74: return 1;  // Rs,Rd
         7'h31, 7'h33, 7'h13, 7'h1C, 7'h1E, 7'h10, 7'h35, 7'h19: return 4;  // memory
         7'h1F:                                                    return 2;  // branch
         default:                                                  return 3;
      endcase
   endfunction

   function automatic int findWord(input logic [`M4_INS_W-1:0] w);
      for (int i = 0; i < numTable; i++)
         if (tblWord[i] == w)
            return i;
      return -1;
   endfunction

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic strobeWord(input logic [`M4_INS_W-1:0] w);
      while (insFull)
         idleCycles(1);   // bus side holds off
      insStrobe = 1'b1;
      insWord   = w;
      idleCycles(1);
      insStrobe = 1'b0;
   endtask

   task waitIdle();
      while (headValid || busy || halted)
         idleCycles(1);
   endtask

   // scoreboard upkeep on every edge
   always @(posedge clk) begin
      int idx;
      cyc <= cyc + 1;
      if (rstN) begin
         if (insDone || trap) begin
            if (sbAddr.size() == 0) begin
               reportFailure("completion seen with no word outstanding");
            end else begin
               void'(sbAddr.pop_front());
               void'(sbBf.pop_front());
               void'(sbDue.pop_front());
               void'(sbTimed.pop_front());
            end
            if (insDone)
               doneCount++;
            if (trap)
               trapCount++;
         end
         if (insStrobe && !insFull) begin
            idx = findWord(insWord);
            if (idx < 0) begin
               reportFailure("strobed word missing from the opcode table");
            end else begin
               sbTimed.push_back(sbAddr.size() == 0 && !halted);
               sbAddr.push_back(tblAddr[idx]);
               sbBf.push_back(tblBf[idx]);
               // raised 2 + stepLen + 1 edges after capture and sampled one edge later
               sbDue.push_back(cyc + 2 + (cyclesFor(tblAddr[idx]) - 1) + 1 + 1);
            end
         end
      end
      headValid <= (sbAddr.size() > 0);
      if (sbAddr.size() > 0) begin
         headAddr  <= sbAddr[0];
         headBf    <= sbBf[0];
         headDue   <= sbDue[0];
         headTimed <= sbTimed[0];
      end
   end

   doneEntry: assert property (@(posedge clk) disable iff (!rstN)
      insDone |-> (headValid && headAddr != `M4_UA_UNDEF && doneAddr == headAddr))
      else reportValue("doneAddr", $sampled(headAddr), $sampled(doneAddr));

   doneTiming: assert property (@(posedge clk) disable iff (!rstN)
      (insDone && headValid && headTimed) |-> (cyc == headDue))
      else reportValue("insDone cycle", $sampled(headDue), $sampled(cyc));

   busyEntry: assert property (@(posedge clk) disable iff (!rstN)
      busy |-> (headValid && uAddr == headAddr))
      else reportValue("uAddr", $sampled(headAddr), $sampled(uAddr));

   busyByte: assert property (@(posedge clk) disable iff (!rstN)
      busy |-> (byteOp == headBf))
      else reportValue("byteOp", $sampled(headBf), $sampled(byteOp));

   trapEntry: assert property (@(posedge clk) disable iff (!rstN)
      trap |-> (headValid && headAddr == `M4_UA_UNDEF))
      else reportValue("trap entry", `M4_UA_UNDEF, $sampled(headAddr));

   trapOnce: assert property (@(posedge clk) disable iff (!rstN) trap |=> !trap)
      else reportFailure("trap held high for more than one cycle");

   haltIdle: assert property (@(posedge clk) disable iff (!rstN) halted |-> !busy)
      else reportFailure("busy high while halted");

   haltHolds: assert property (@(posedge clk) disable iff (!rstN)
      (halted && !cont) |=> halted)
      else reportFailure("halted dropped without cont");

   haltAfterDone: assert property (@(posedge clk) disable iff (!rstN)
      (insDone && doneAddr == `M4_UA_HALT) |-> halted)
      else reportFailure("halt instruction completed without halting");

   initial begin
      repeat (tickLimit) @(posedge clk);
      $display("watchdog: run timed out after %0d cycles", tickLimit);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      int order [numDirected];
      int j;
      int tmp;
      int seedVal;
      seedVal   = $urandom(51);  // one seed for the whole run
      rstN      = 1'b0;
      insStrobe = 1'b0;
      insWord   = '0;
      cont      = 1'b0;
      cyc       = 0;
      errCount  = 0;
      doneCount = 0;
      trapCount = 0;
      headValid = 1'b0;
      headTimed = 1'b0;
      testName  = "reset";
      setEntry(0,  16'o010102, 7'h30, 1'b0);  // mov r1,r2
      setEntry(1,  16'o011102, 7'h31, 1'b0);  // mov (r1),r2
      setEntry(2,  16'o110102, 7'h32, 1'b1);  // movb r1,r2
      setEntry(3,  16'o111102, 7'h33, 1'b1);  // movb (r1),r2
      setEntry(4,  16'o060102, 7'h74, 1'b0);  // add r1,r2
      setEntry(5,  16'o060112, 7'h34, 1'b0);  // add r1,(r2)
      setEntry(6,  16'o061102, 7'h35, 1'b0);  // add (r1),r2
      setEntry(7,  16'o005003, 7'h22, 1'b0);  // clr r3
      setEntry(8,  16'o005013, 7'h12, 1'b0);  // clr (r3)
      setEntry(9,  16'o105013, 7'h25, 1'b1);  // clrb (r3)
      setEntry(10, 16'o000401, 7'h1F, 1'b0);  // br
      setEntry(11, 16'o001002, 7'h1F, 1'b0);  // bne
      setEntry(12, 16'o004715, 7'h37, 1'b0);  // jsr pc,(r5)
      setEntry(13, 16'o000007, `M4_UA_UNDEF, 1'b0);
      setEntry(14, 16'o170000, `M4_UA_UNDEF, 1'b0);
      setEntry(15, 16'o000000, `M4_UA_HALT, 1'b0);
      repeat (3) @(posedge clk);
      #2 rstN = 1'b1;
      idleCycles(2);

      testName = "decode";  // shuffled words with random gaps
      for (int i = 0; i < numDirected; i++)
         order[i] = i;
      for (int i = numDirected - 1; i > 0; i--) begin
         j        = $urandom % (i + 1);
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      foreach (order[k]) begin
         strobeWord(tblWord[order[k]]);
         idleCycles($urandom % 4);
      end
      waitIdle();

      testName = "timing";  // one at a time into an idle front end
      for (int i = 0; i < numDirected; i++) begin
         strobeWord(tblWord[i]);
         waitIdle();
      end

      testName = "undef";
      strobeWord(16'o000007);
      strobeWord(16'o010102);
      strobeWord(16'o170000);
      strobeWord(16'o061102);
      waitIdle();

      testName = "halt";
      strobeWord(16'o000000);
      while (!halted)
         idleCycles(1);
      testName = "backpressure";
      strobeWord(16'o005003);
      strobeWord(16'o110102);
      assert (insFull) else reportFailure("insFull low with two words held during halt");
      fork
         begin
            idleCycles(4);
            assert (insFull && halted && !busy) else reportFailure("queue drained while halted");
            cont = 1'b1;
            idleCycles(1);
            cont = 1'b0;
         end
         strobeWord(16'o004715);  // held back until insFull falls
      join
      waitIdle();

      testName = "stream";  // first word is popped at once
      strobeWord(16'o011102);
      strobeWord(16'o060112);
      strobeWord(16'o105013);
      assert (insFull) else reportFailure("insFull low after back-to-back strobes");
      strobeWord(16'o001002);
      waitIdle();

      idleCycles(2);
      testName = "summary";
      assert (!headValid) else reportFailure("words left outstanding at the end");
      assert (doneCount == wordCount - 2)
         else reportValue("completions", wordCount - 2, doneCount);
      assert (trapCount == 2) else reportValue("traps", 2, trapCount);
      $display("completions %0d, traps %0d, errors %0d", doneCount, trapCount, errCount);
      if (errCount == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* m4Decode.f */
+incdir+.
m4Pkg.sv
plmDec.sv
insQueue.sv
mcRom.sv
mcSequencer.sv
m4Decode.sv
m4DecodeTb.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := m4DecodeTb
FLIST    := m4Decode.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FLIST)) m4_config.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
